// ==== disparity_sad.sv ====
`timescale 1ns/1ps

module disparity_sad
  import stereo_pkg::*;
#(
  parameter int WIN = 4
) (
  input  logic       tm3_clk_v0,
  input  logic       rst_n,
  input  logic       pix_valid,
  input  pix_s       pix,
  input  logic [1:0] sel,
  output logic       score_valid,
  output logic [1:0] best_disp,
  output score_t     bus_word
);

  localparam int LW = WIN + 3;  // Left history must reach disparity 3

  pix_t       r_hist  [WIN];
  pix_t       l_hist  [LW];
  pix_t       r_next  [WIN];
  score_t     sad     [4];
  score_t     score_q [4];
  score_t     best_sad;
  logic [1:0] best;
  logic       left_pix;
  logic       right_pix;

  function automatic score_t abs_diff(input pix_t a, input pix_t b);
    pix_t diff;
    diff = (a > b) ? (a - b) : (b - a);
    return score_t'(diff);
  endfunction

  assign left_pix  = pix_valid && (pix.side == SIDE_LEFT);
  assign right_pix = pix_valid && (pix.side == SIDE_RIGHT);

  // Right history as it will look once the arriving pixel is shifted in
  always_comb begin
    r_next[0] = pix.data;
    for (int i = 1; i < WIN; i++) begin
      r_next[i] = r_hist[i-1];
    end
  end

  always_comb begin
    for (int d = 0; d < 4; d++) begin
      sad[d] = '0;
      for (int i = 0; i < WIN; i++) begin
        sad[d] = sad[d] + abs_diff(r_next[i], l_hist[i+d]);
      end
    end
  end

  // Strict compare keeps the lowest disparity on a tie
  always_comb begin
    best     = 2'd0;
    best_sad = sad[0];
    for (int d = 1; d < 4; d++) begin
      if (sad[d] < best_sad) begin
        best     = 2'(d);
        best_sad = sad[d];
      end
    end
  end

  always_ff @(posedge tm3_clk_v0) begin
    if (!rst_n) begin
      for (int i = 0; i < WIN; i++) begin
        r_hist[i] <= '0;
      end
      for (int i = 0; i < LW; i++) begin
        l_hist[i] <= '0;
      end
    end else begin
      if (right_pix) begin
        r_hist <= r_next;
      end
      if (left_pix) begin
        l_hist[0] <= pix.data;
        for (int i = 1; i < LW; i++) begin
          l_hist[i] <= l_hist[i-1];
        end
      end
    end
  end

  always_ff @(posedge tm3_clk_v0) begin
    if (!rst_n) begin
      for (int d = 0; d < 4; d++) begin
        score_q[d] <= '0;
      end
      best_disp   <= 2'd0;
      score_valid <= 1'b0;
    end else begin
      score_valid <= right_pix;  // One pulse per right pixel
      if (right_pix) begin
        score_q   <= sad;
        best_disp <= best;
      end
    end
  end

  // Registered 4-to-1 word select onto the score bus
  always_ff @(posedge tm3_clk_v0) begin
    if (!rst_n) begin
      bus_word <= '0;
    end else begin
      bus_word <= score_q[sel];
    end
  end

endmodule

// ==== pixel_splitter.sv ====
`timescale 1ns/1ps

module pixel_splitter
  import stereo_pkg::*;
(
  input  logic tm3_clk_v0,
  input  logic rst_n,
  input  logic new_data,
  input  pix_s pix_in,
  output logic pix_valid,
  output pix_s pix_out,
  output pix_t rgb_left,
  output pix_t rgb_right
);

  logic take_left;
  logic take_right;

  assign take_left  = new_data && (pix_in.side == SIDE_LEFT);
  assign take_right = new_data && (pix_in.side == SIDE_RIGHT);

  always_ff @(posedge tm3_clk_v0) begin
    if (!rst_n) begin
      pix_valid <= 1'b0;
    end else begin
      pix_valid <= new_data;  // Strobe delayed along with the pixel
    end
  end

  always_ff @(posedge tm3_clk_v0) begin
    if (new_data) begin
      pix_out <= pix_in;
    end
  end

  // Each side holds its last pixel until a new one of that side arrives
  always_ff @(posedge tm3_clk_v0) begin
    if (!rst_n) begin
      rgb_left  <= '0;
      rgb_right <= '0;
    end else begin
      if (take_left) begin
        rgb_left <= pix_in.data;
      end
      if (take_right) begin
        rgb_right <= pix_in.data;
      end
    end
  end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f sim.f --top-module tb_stereo -o tb_stereo || exit 1
out=$(./obj_dir/tb_stereo 2>&1)
echo "$out"
echo "$out" | grep -qx "all tests passed" && exit 0 || exit 1

// ==== sim.f ====
stereo_pkg.sv
pixel_splitter.sv
sram_frame_port.sv
disparity_sad.sv
stereo_wrapper.sv
stereo_asserts.sv
tb_stereo.sv

// ==== sram_frame_port.sv ====
`timescale 1ns/1ps

module sram_frame_port
  import stereo_pkg::*;
#(
  parameter int SRAM_AW = 19
) (
  input  logic     tm3_clk_v0,
  input  logic     rst_n,
  input  logic     pix_valid,
  input  pix_s     pix,
  output sram_wr_s wr,
  output logic     adsp_n
);

  logic [2:0]         lane_cnt [2];  // Next byte lane, one counter per camera
  logic [63:0]        asm_word [2];
  logic [18:0]        pix_word;
  logic [SRAM_AW-1:0] word_addr;
  logic               last_lane;
  logic               wr_fire;
  logic [18:0]        wr_addr;
  logic [63:0]        wr_data;
  logic [7:0]         wr_be_n;

  assign pix_word  = pix.addr >> 3;  // Eight pixels per SRAM word
  assign word_addr = {pix.side, pix_word[SRAM_AW-2:0]};
  assign last_lane = (lane_cnt[pix.side] == 3'd7);
  assign wr_fire   = pix_valid && last_lane;

  always_ff @(posedge tm3_clk_v0) begin
    if (!rst_n) begin
      lane_cnt[0] <= '0;
      lane_cnt[1] <= '0;
    end else if (pix_valid) begin
      lane_cnt[pix.side] <= lane_cnt[pix.side] + 3'd1;  // Rolls back to lane 0 after byte 7
    end
  end

  always_ff @(posedge tm3_clk_v0) begin
    if (pix_valid) begin
      asm_word[pix.side][{lane_cnt[pix.side], 3'b000} +: 8] <= pix.data;
    end
  end

  always_ff @(posedge tm3_clk_v0) begin
    if (!rst_n) begin
      wr_be_n <= '1;
      adsp_n  <= 1'b1;
    end else begin
      wr_be_n <= wr_fire ? 8'h00 : 8'hff;  // All lanes written together
      adsp_n  <= !wr_fire;
    end
  end

  // The eighth pixel goes straight into the top byte of the outgoing word
  always_ff @(posedge tm3_clk_v0) begin
    if (wr_fire) begin
      wr_addr <= 19'(word_addr);
      wr_data <= {pix.data, asm_word[pix.side][55:0]};
    end
  end

  assign wr = '{addr: wr_addr, data: wr_data, be_n: wr_be_n};

endmodule

// ==== stereo_asserts.sv ====
`timescale 1ns/1ps

module stereo_asserts (
  input logic        tm3_clk_v0,
  input logic        rst_n,
  input logic        score_valid,
  input logic [18:0] offchip_sram_addr,
  input logic [7:0]  offchip_sram_we,
  input logic        tm3_sram_adsp
);

  logic write_cycle;

  assign write_cycle = !tm3_sram_adsp;

  adsp_matches_we: assert property (@(posedge tm3_clk_v0)
      rst_n |-> (write_cycle == (offchip_sram_we == 8'h00)))
    else $error("tm3_sram_adsp and offchip_sram_we disagree about a write cycle");

  // A side needs eight pixels per word, so its writes are never adjacent
  no_adjacent_side_write: assert property (@(posedge tm3_clk_v0) disable iff (!rst_n)
      write_cycle |=> !(write_cycle && offchip_sram_addr[18] == $past(offchip_sram_addr[18])))
    else $error("two SRAM writes for the same side in consecutive cycles");

  quiet_after_reset: assert property (@(posedge tm3_clk_v0) !rst_n |=> !score_valid)
    else $error("score_valid high in the cycle right after reset");

endmodule

bind stereo_wrapper stereo_asserts u_asserts (
  .tm3_clk_v0        (tm3_clk_v0),
  .rst_n             (rst_n),
  .score_valid       (score_valid),
  .offchip_sram_addr (offchip_sram_addr),
  .offchip_sram_we   (offchip_sram_we),
  .tm3_sram_adsp     (tm3_sram_adsp)
);

// ==== stereo_pkg.sv ====
package stereo_pkg;

  typedef logic [7:0]  pix_t;
  typedef logic [15:0] score_t;

  localparam logic SIDE_LEFT  = 1'b0;
  localparam logic SIDE_RIGHT = 1'b1;

  // One pixel as it comes off the video source
  typedef struct packed {
    logic        side;  // Camera that produced the pixel
    pix_t        data;
    logic [18:0] addr;  // Frame address of the pixel
  } pix_s;

  // One write cycle towards the off-chip SRAM
  typedef struct packed {
    logic [18:0] addr;  // Word address
    logic [63:0] data;  // Eight pixels, oldest in byte 0
    logic [7:0]  be_n;  // Active low byte write enables
  } sram_wr_s;

endpackage

// ==== stereo_wrapper.sv ====
`timescale 1ns/1ps

module stereo_wrapper
  import stereo_pkg::*;
#(
  parameter int WIN     = 4,
  parameter int SRAM_AW = 19
) (
  input  logic        tm3_clk_v0,
  input  logic        rst_n,
  input  logic        vidin_new_data,
  input  pix_t        vidin_rgb_reg,
  input  logic [18:0] vidin_addr_reg,
  input  logic        svid_comp_switch,
  input  logic [1:0]  sel_mux_bus_word_temp_2to1,
  output score_t      bus_word_temp_2to1,
  output logic [1:0]  best_disp,
  output logic        score_valid,
  output logic        vidin_new_data_fifo,
  output pix_t        vidin_rgb_reg_fifo_left,
  output pix_t        vidin_rgb_reg_fifo_right,
  output logic [18:0] offchip_sram_addr,
  output logic [63:0] offchip_sram_data_out,
  output logic [7:0]  offchip_sram_we,
  output logic        tm3_sram_adsp
);

  pix_s     pix_in;
  pix_s     pix_q;
  logic     pix_valid;
  sram_wr_s sram_wr;

  assign pix_in = '{side: svid_comp_switch, data: vidin_rgb_reg, addr: vidin_addr_reg};

  pixel_splitter u_split (
    .tm3_clk_v0 (tm3_clk_v0),
    .rst_n      (rst_n),
    .new_data   (vidin_new_data),
    .pix_in     (pix_in),
    .pix_valid  (pix_valid),
    .pix_out    (pix_q),
    .rgb_left   (vidin_rgb_reg_fifo_left),
    .rgb_right  (vidin_rgb_reg_fifo_right)
  );

  sram_frame_port #(
    .SRAM_AW (SRAM_AW)
  ) u_sram (
    .tm3_clk_v0 (tm3_clk_v0),
    .rst_n      (rst_n),
    .pix_valid  (pix_valid),
    .pix        (pix_q),
    .wr         (sram_wr),
    .adsp_n     (tm3_sram_adsp)
  );

  disparity_sad #(
    .WIN (WIN)
  ) u_sad (
    .tm3_clk_v0  (tm3_clk_v0),
    .rst_n       (rst_n),
    .pix_valid   (pix_valid),
    .pix         (pix_q),
    .sel         (sel_mux_bus_word_temp_2to1),
    .score_valid (score_valid),
    .best_disp   (best_disp),
    .bus_word    (bus_word_temp_2to1)
  );

  assign vidin_new_data_fifo   = pix_valid;
  assign offchip_sram_addr     = sram_wr.addr;
  assign offchip_sram_data_out = sram_wr.data;
  assign offchip_sram_we       = sram_wr.be_n;  // Write enables idle high between writes

endmodule

// ==== tb_stereo.sv ====
`timescale 1ns/1ps

module tb_stereo
  import stereo_pkg::*;
();

  localparam int WIN = 4;
  localparam int LW  = WIN + 3;

  typedef struct packed {
    logic        strobe;
    logic        side;
    pix_t        data;
    logic [18:0] addr;
    logic [1:0]  sel;
  } step_s;

  logic        tm3_clk_v0;
  logic        rst_n;
  logic        vidin_new_data;
  pix_t        vidin_rgb_reg;
  logic [18:0] vidin_addr_reg;
  logic        svid_comp_switch;
  logic [1:0]  sel_mux_bus_word_temp_2to1;
  score_t      bus_word_temp_2to1;
  logic [1:0]  best_disp;
  logic        score_valid;
  logic        vidin_new_data_fifo;
  pix_t        vidin_rgb_reg_fifo_left;
  pix_t        vidin_rgb_reg_fifo_right;
  logic [18:0] offchip_sram_addr;
  logic [63:0] offchip_sram_data_out;
  logic [7:0]  offchip_sram_we;
  logic        tm3_sram_adsp;

  step_s       steps [$];
  logic [18:0] next_addr [2];
  int          pix_count [2];
  int          errors;
  int          checks;
  int          writes_seen;

  logic        m_pv;  // Model of the registered pixel stage
  pix_s        m_pix;
  pix_t        m_left;
  pix_t        m_right;
  int          m_cnt [2];
  logic [63:0] m_pack [2];
  logic        m_wr;
  logic [18:0] m_wr_addr;
  logic [63:0] m_wr_data;
  pix_t        m_r [WIN];
  pix_t        m_l [LW];
  score_t      m_score [4];
  logic [1:0]  m_best;
  logic        m_sv;
  score_t      m_bus;

  stereo_wrapper #(.WIN(WIN), .SRAM_AW(19)) UUT (.*);

  always #10 tm3_clk_v0 = ~tm3_clk_v0;

  function automatic score_t pix_dist(input pix_t a, input pix_t b);
    int diff;
    diff = int'(a) - int'(b);
    if (diff < 0) begin
      diff = -diff;
    end
    return score_t'(diff);
  endfunction

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("MISMATCH %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic add_step(input logic strobe, input logic side, input pix_t data,
                          input logic [1:0] sel);
    step_s s;
    s.strobe = strobe;
    s.side   = side;
    s.data   = data;
    s.sel    = sel;
    s.addr   = next_addr[side];
    if (strobe) begin
      next_addr[side] = next_addr[side] + 19'd1;
      pix_count[side]++;
    end
    steps.push_back(s);
  endtask

  task automatic build_table();
    pix_t level;
    repeat (4) add_step(1'b0, 1'b0, 8'h00, 2'd0);  // Quiet bus right after reset
    add_step(1'b1, 1'b0, 8'h11, 2'd0);
    add_step(1'b1, 1'b1, 8'h22, 2'd0);
    add_step(1'b0, 1'b0, 8'h00, 2'd0);
    add_step(1'b1, 1'b0, 8'h33, 2'd0);
    for (int k = 0; k < 8; k++) begin
      add_step(1'b1, 1'b0, pix_t'($urandom), 2'd0);
      if (k % 3 == 1) begin
        add_step(1'b1, 1'b1, pix_t'($urandom), 2'd0);  // Other side in between
      end
      add_step(1'b0, 1'b0, 8'h00, 2'd0);
    end
    for (int k = 0; k < 40; k++) begin
      add_step(1'b1, 1'(k % 2), pix_t'($urandom), 2'(k));
      repeat ($urandom_range(2)) add_step(1'b0, 1'b0, 8'h00, 2'(k));
    end
    for (int s = 0; s < 4; s++) begin
      add_step(1'b0, 1'b0, 8'h00, 2'(s));  // Random scores held while the select steps
      add_step(1'b0, 1'b0, 8'h00, 2'(s));
    end
    level = pix_t'($urandom);
    for (int k = 0; k < 16; k++) begin
      add_step(1'b1, 1'(k % 2), level, 2'd0);  // Flat image ends in a four-way tie
    end
    for (int k = 0; k < 32; k++) begin
      add_step(1'b1, 1'($urandom), pix_t'($urandom), 2'(k / 8));
    end
    repeat (4) add_step(1'b0, 1'b0, 8'h00, 2'd0);
  endtask

  task automatic advance_model();
    score_t bus_next;
    score_t low;
    int     sd;
    if (!rst_n) begin
      m_pv = 1'b0;
      m_left = '0;
      m_right = '0;
      m_wr = 1'b0;
      m_sv = 1'b0;
      m_best = 2'd0;
      m_bus = '0;
      for (int s = 0; s < 2; s++) begin
        m_cnt[s] = 0;
        m_pack[s] = '0;
      end
      for (int i = 0; i < WIN; i++) begin
        m_r[i] = '0;
      end
      for (int i = 0; i < LW; i++) begin
        m_l[i] = '0;
      end
      for (int d = 0; d < 4; d++) begin
        m_score[d] = '0;
      end
    end else begin
      bus_next = m_score[sel_mux_bus_word_temp_2to1];  // Select sees the scores before this edge
      m_wr = 1'b0;
      m_sv = 1'b0;
      if (m_pv) begin
        sd = m_pix.side ? 1 : 0;
        m_pack[sd][8*m_cnt[sd] +: 8] = m_pix.data;
        if (m_cnt[sd] == 7) begin
          m_wr = 1'b1;
          m_wr_addr = {m_pix.side, 18'(m_pix.addr >> 3)};
          m_wr_data = m_pack[sd];
          m_cnt[sd] = 0;
        end else begin
          m_cnt[sd]++;
        end
        if (m_pix.side) begin
          for (int i = WIN - 1; i > 0; i--) begin
            m_r[i] = m_r[i-1];
          end
          m_r[0] = m_pix.data;
          for (int d = 0; d < 4; d++) begin
            m_score[d] = '0;
            for (int i = 0; i < WIN; i++) begin
              m_score[d] = m_score[d] + pix_dist(m_r[i], m_l[i+d]);
            end
          end
          m_best = 2'd0;
          low = m_score[0];
          for (int d = 1; d < 4; d++) begin
            if (m_score[d] < low) begin
              m_best = 2'(d);
              low = m_score[d];
            end
          end
          m_sv = 1'b1;
        end else begin
          for (int i = LW - 1; i > 0; i--) begin
            m_l[i] = m_l[i-1];
          end
          m_l[0] = m_pix.data;
        end
      end
      m_bus = bus_next;
      m_pv = vidin_new_data;
      if (vidin_new_data) begin
        m_pix = '{side: svid_comp_switch, data: vidin_rgb_reg, addr: vidin_addr_reg};
        if (svid_comp_switch) begin
          m_right = vidin_rgb_reg;
        end else begin
          m_left = vidin_rgb_reg;
        end
      end
    end
  endtask

  task automatic compare_outputs();
    check_value("vidin_new_data_fifo", 64'(vidin_new_data_fifo), 64'(m_pv));
    check_value("vidin_rgb_reg_fifo_left", 64'(vidin_rgb_reg_fifo_left), 64'(m_left));
    check_value("vidin_rgb_reg_fifo_right", 64'(vidin_rgb_reg_fifo_right), 64'(m_right));
    check_value("score_valid", 64'(score_valid), 64'(m_sv));
    if (m_sv) begin
      check_value("best_disp", 64'(best_disp), 64'(m_best));
    end
    check_value("bus_word_temp_2to1", 64'(bus_word_temp_2to1), 64'(m_bus));
    check_value("offchip_sram_we", 64'(offchip_sram_we), m_wr ? 64'h00 : 64'hff);
    check_value("tm3_sram_adsp", 64'(tm3_sram_adsp), 64'(!m_wr));
    if (m_wr) begin
      check_value("offchip_sram_addr", 64'(offchip_sram_addr), 64'(m_wr_addr));
      check_value("offchip_sram_data_out", offchip_sram_data_out, m_wr_data);
    end
    if (offchip_sram_we == 8'h00) begin
      writes_seen++;
    end
  endtask

  // Model steps on the same edge as the DUT, outputs are compared once settled
  always @(posedge tm3_clk_v0) begin
    advance_model();
    #2;
    compare_outputs();
  end

  task automatic wait_idle();
    int quiet;
    int cycles;
    quiet = 0;
    cycles = 0;
    while (quiet < 3 && cycles < 50) begin
      @(posedge tm3_clk_v0);
      #3;
      cycles++;
      if (!vidin_new_data_fifo && !score_valid && tm3_sram_adsp) begin
        quiet++;
      end else begin
        quiet = 0;
      end
    end
    if (quiet < 3) begin
      errors++;
      $display("Timeout: the DUT did not go idle within 50 cycles");
    end
  endtask

  initial begin
    void'($urandom(92528));
    tm3_clk_v0 = 1'b0;
    rst_n = 1'b0;
    vidin_new_data = 1'b0;
    vidin_rgb_reg = '0;
    vidin_addr_reg = '0;
    svid_comp_switch = 1'b0;
    sel_mux_bus_word_temp_2to1 = 2'd0;
    errors = 0;
    checks = 0;
    writes_seen = 0;
    next_addr[0] = '0;
    next_addr[1] = '0;
    pix_count[0] = 0;
    pix_count[1] = 0;
    build_table();
    repeat (10) @(posedge tm3_clk_v0);
    #1 rst_n = 1'b1;
    foreach (steps[k]) begin
      @(posedge tm3_clk_v0);
      #1;
      vidin_new_data = steps[k].strobe;
      vidin_rgb_reg = steps[k].data;
      vidin_addr_reg = steps[k].addr;
      svid_comp_switch = steps[k].side;
      sel_mux_bus_word_temp_2to1 = steps[k].sel;
    end
    wait_idle();
    check_value("write count", 64'(writes_seen), 64'(pix_count[0] / 8 + pix_count[1] / 8));
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule
